/* Makefile */
VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+rtl
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/decodeIf.sv
rtl/fetchUnit.sv
rtl/instrDecoder.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/memAccess.sv
rtl/riscvCore.sv
verification/clockGen.sv
verification/coreTb.sv

/* rtl/corePkg.sv */
`default_nettype none

package corePkg;

    // Encoding follows funct3 for the base ops, the alternates sit above
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SLL  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        XOR  = 4'd4,
        SRL  = 4'd5,
        OR   = 4'd6,
        AND  = 4'd7,
        SUB  = 4'd8,
        SRA  = 4'd9
    } aluOpT;

    typedef enum logic [1:0] {
        PC_SEQ,     // pc + 4
        PC_JAL,     // pc + imm
        PC_JALR,    // rs1 + imm, bit 0 cleared
        PC_BRANCH   // pc + imm when taken
    } pcSelT;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wbSelT;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,     // AUIPC
        OPA_PC4,    // Link address for JAL and JALR
        OPA_ZERO    // LUI
    } opASelT;

endpackage

`default_nettype wire

/* rtl/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// One write enable per byte of a data word
`define BYTE_EN_W (`XLEN / 8)

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* rtl/decodeIf.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

interface decodeIf
    import corePkg::*;
();
    aluOpT                  aluOp;
    opASelT                 opASel;
    logic                   useImm;     // Operand B is imm instead of rs2
    logic                   regWrite;
    wbSelT                  wbSel;
    pcSelT                  pcSel;
    logic                   isLoad;
    logic                   isStore;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic [`XLEN-1:0]       imm;

    modport source (output aluOp, opASel, useImm, regWrite, wbSel, pcSel,
                    isLoad, isStore, funct3, rs1Addr, rs2Addr, rdAddr, imm);

    // Register file and ALU side
    modport exec (input aluOp, opASel, useImm, funct3, imm,
                  rs1Addr, rs2Addr, rdAddr, regWrite);

    // Memory access and next-PC side
    modport mem (input isLoad, isStore, funct3, wbSel, pcSel, imm);

endinterface

`default_nettype wire

/* rtl/executeUnit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module executeUnit
    import isaPkg::*;
    import corePkg::*;
(
    decodeIf.exec                 dec,
    input  wire logic [`XLEN-1:0] pc,
    input  wire logic [`XLEN-1:0] rs1Data,
    input  wire logic [`XLEN-1:0] rs2Data,
    output logic      [`XLEN-1:0] aluResult,
    output logic                  branchTaken
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic             resultZero;

    always_comb
    begin
        case (dec.opASel)
            OPA_PC:   opA = pc;
            OPA_PC4:  opA = pc + `XLEN'd4;
            OPA_ZERO: opA = '0;
            default:  opA = rs1Data;
        endcase
    end

    assign opB   = dec.useImm ? dec.imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb
    begin
        case (dec.aluOp)
            ADD:     aluResult = opA + opB;
            SUB:     aluResult = opA - opB;
            SLL:     aluResult = opA << shamt;
            SLT:     aluResult = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            SLTU:    aluResult = {{(`XLEN-1){1'b0}}, opA < opB};
            XOR:     aluResult = opA ^ opB;
            SRL:     aluResult = opA >> shamt;
            SRA:     aluResult = $signed(opA) >>> shamt;
            OR:      aluResult = opA | opB;
            AND:     aluResult = opA & opB;
            default: aluResult = '0;
        endcase
    end

    assign resultZero = (aluResult == '0);

    // Only looked at by fetch when the instruction is a branch
    always_comb
    begin
        case (dec.funct3)
            F3_BEQ, F3_BGE, F3_BGEU: branchTaken = resultZero;
            F3_BNE:                  branchTaken = !resultZero;
            F3_BLT, F3_BLTU:         branchTaken = (aluResult == `XLEN'd1);
            default:                 branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module fetchUnit
    import corePkg::*;
(
    input  wire logic             clk,
    input  wire logic             reset,
    decodeIf.mem                  dec,
    input  wire logic [`XLEN-1:0] rs1Data,
    input  wire logic             branchTaken,
    output logic      [`XLEN-1:0] iaddr
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget;    // Shared by JAL and branches
    logic [`XLEN-1:0] jalrTarget;
    logic [`XLEN-1:0] nextPc;

    assign pcPlus4    = pc + `XLEN'd4;
    assign pcTarget   = pc + dec.imm;
    assign jalrTarget = (rs1Data + dec.imm) & ~`XLEN'd1;

    always_comb
    begin
        case (dec.pcSel)
            PC_JAL:    nextPc = pcTarget;
            PC_JALR:   nextPc = jalrTarget;
            PC_BRANCH: nextPc = branchTaken ? pcTarget : pcPlus4;
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= nextPc;
    end

    assign iaddr = pc;

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module instrDecoder
    import isaPkg::*;
    import corePkg::*;
(
    input  wire logic [`XLEN-1:0] idata,
    decodeIf.source               dec
);

    opcodeT           opcode;
    logic [2:0]       funct3;
    logic             altBit;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    logic [`XLEN-1:0] immShamt;

    assign opcode = opcodeT'(idata[OPCODE_MSB:0]);
    assign funct3 = idata[F3_LSB +: 3];
    assign altBit = idata[ALT_BIT];

    // Immediate formats
    assign immI     = {{20{idata[SIGN_BIT]}}, idata[31:20]};
    assign immS     = {{20{idata[SIGN_BIT]}}, idata[31:25], idata[11:7]};
    assign immB     = {{20{idata[SIGN_BIT]}}, idata[7], idata[30:25], idata[11:8], 1'b0};
    assign immU     = {idata[31:12], 12'd0};
    assign immJ     = {{12{idata[SIGN_BIT]}}, idata[19:12], idata[20], idata[30:21], 1'b0};
    assign immShamt = {{(`XLEN-5){1'b0}}, idata[24:20]};  // Zero-extended

    // ALU op for R and I forms, bit 30 only means SUB in the R form
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt,
                                            input logic isReg);
        case (f3)
            F3_ADD:  return (isReg && alt) ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return alt ? SRA : SRL;
            F3_OR:   return OR;
            default: return AND;
        endcase
    endfunction

    always_comb
    begin
        dec.aluOp    = ADD;
        dec.opASel   = OPA_RS1;
        dec.useImm   = 1'b0;
        dec.regWrite = 1'b0;
        dec.wbSel    = WB_ALU;
        dec.pcSel    = PC_SEQ;
        dec.isLoad   = 1'b0;
        dec.isStore  = 1'b0;
        dec.imm      = '0;
        dec.funct3   = funct3;
        dec.rdAddr   = idata[RD_LSB +: `REG_ADDR_W];
        dec.rs1Addr  = idata[RS1_LSB +: `REG_ADDR_W];
        dec.rs2Addr  = '0;    // x0 unless the format carries rs2

        case (opcode)
            ALUR:
            begin
                dec.aluOp    = aluFromFunct3(funct3, altBit, 1'b1);
                dec.rs2Addr  = idata[RS2_LSB +: `REG_ADDR_W];
                dec.regWrite = 1'b1;
            end
            ALUI:
            begin
                dec.aluOp    = aluFromFunct3(funct3, altBit, 1'b0);
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.imm      = (funct3 == F3_SLL || funct3 == F3_SR) ? immShamt : immI;
            end
            LOAD:
            begin
                dec.useImm   = 1'b1;
                dec.imm      = immI;
                dec.isLoad   = 1'b1;
                dec.wbSel    = WB_MEM;
                dec.regWrite = 1'b1;
            end
            STORE:
            begin
                dec.useImm  = 1'b1;
                dec.imm     = immS;
                dec.rs2Addr = idata[RS2_LSB +: `REG_ADDR_W];
                dec.isStore = 1'b1;
            end
            LUI, AUIPC:
            begin
                dec.opASel   = (opcode == LUI) ? OPA_ZERO : OPA_PC;
                dec.useImm   = 1'b1;
                dec.imm      = immU;
                dec.rs1Addr  = '0;
                dec.regWrite = 1'b1;
            end
            JAL, JALR:
            begin
                dec.opASel   = OPA_PC4;   // Link value is pc + 4 + x0
                dec.imm      = (opcode == JAL) ? immJ : immI;
                dec.pcSel    = (opcode == JAL) ? PC_JAL : PC_JALR;
                dec.rs1Addr  = (opcode == JAL) ? '0 : idata[RS1_LSB +: `REG_ADDR_W];
                dec.regWrite = 1'b1;
            end
            BRANCH:
            begin
                dec.rs2Addr = idata[RS2_LSB +: `REG_ADDR_W];
                dec.imm     = immB;
                dec.pcSel   = PC_BRANCH;
                case (funct3)
                    F3_BEQ, F3_BNE:   dec.aluOp = SUB;
                    F3_BLT, F3_BGE:   dec.aluOp = SLT;
                    F3_BLTU, F3_BGEU: dec.aluOp = SLTU;
                    default:          dec.aluOp = ADD;
                endcase
            end
            default:
            begin
                dec.rs1Addr = '0;    // Unknown opcode behaves as a NOP
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        ALUR   = 7'b0110011,
        ALUI   = 7'b0010011,
        STORE  = 7'b0100011,
        LOAD   = 7'b0000011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcodeT;

    // ALU funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'd0;  // ADD and SUB
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;  // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    // Word-only memory access
    localparam logic [2:0] F3_LW = 3'd2;
    localparam logic [2:0] F3_SW = 3'd2;

    // Field positions in the instruction word
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int ALT_BIT    = 30;  // SUB and SRA select
    localparam int SIGN_BIT   = 31;

endpackage

`default_nettype wire

/* rtl/memAccess.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module memAccess
    import isaPkg::*;
    import corePkg::*;
(
    input  wire logic                  reset,
    decodeIf.mem                       dec,
    input  wire logic [`XLEN-1:0]      aluResult,
    input  wire logic [`XLEN-1:0]      rs2Data,
    input  wire logic [`XLEN-1:0]      drdata,
    output logic      [`XLEN-1:0]      daddr,
    output logic      [`XLEN-1:0]      dwdata,
    output logic      [`BYTE_EN_W-1:0] dwe,
    output logic      [`XLEN-1:0]      wdata
);

    logic             wordAligned;
    logic             storeWord;
    logic             loadWord;
    logic [`XLEN-1:0] loadData;

    assign wordAligned = (aluResult[1:0] == 2'b00);
    assign storeWord   = dec.isStore && (dec.funct3 == F3_SW) && wordAligned;
    assign loadWord    = dec.isLoad && (dec.funct3 == F3_LW) && wordAligned;

    // Data bus held quiet during reset
    assign daddr  = reset ? '0 : aluResult;
    assign dwdata = reset ? '0 : rs2Data;
    assign dwe    = (storeWord && !reset) ? '1 : '0;

    // Sub-word and misaligned loads return zero
    assign loadData = loadWord ? drdata : '0;

    assign wdata = (dec.wbSel == WB_MEM) ? loadData : aluResult;

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module registerFile (
    input  wire logic             clk,
    input  wire logic             reset,
    decodeIf.exec                 dec,
    input  wire logic [`XLEN-1:0] wdata,
    output logic      [`XLEN-1:0] rs1Data,
    output logic      [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             writeEn;

    // x0 is never written so it keeps the reset value of zero
    assign writeEn = dec.regWrite && (dec.rdAddr != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn)
        begin
            regs[dec.rdAddr] <= wdata;
        end
    end

    // Asynchronous read ports
    assign rs1Data = regs[dec.rs1Addr];
    assign rs2Data = regs[dec.rs2Addr];

endmodule

`default_nettype wire

/* rtl/riscvCore.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module riscvCore (
    input  wire logic                  clk,
    input  wire logic                  reset,
    output logic      [`XLEN-1:0]      iaddr,
    input  wire logic [`XLEN-1:0]      idata,
    output logic      [`XLEN-1:0]      daddr,
    input  wire logic [`XLEN-1:0]      drdata,
    output logic      [`XLEN-1:0]      dwdata,
    output logic      [`BYTE_EN_W-1:0] dwe
);

    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] wdata;      // Register writeback value
    logic             branchTaken;

    decodeIf decBus ();

    fetchUnit fetch_i (
        .clk         (clk),
        .reset       (reset),
        .dec         (decBus),
        .rs1Data     (rs1Data),
        .branchTaken (branchTaken),
        .iaddr       (iaddr)
    );

    instrDecoder decode_i (
        .idata (idata),
        .dec   (decBus)
    );

    registerFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .dec     (decBus),
        .wdata   (wdata),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    executeUnit execute_i (
        .dec         (decBus),
        .pc          (iaddr),      // PC of the instruction in flight
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    memAccess memAccess_i (
        .reset     (reset),
        .dec       (decBus),
        .aluResult (aluResult),
        .rs2Data   (rs2Data),
        .drdata    (drdata),
        .daddr     (daddr),
        .dwdata    (dwdata),
        .dwe       (dwe),
        .wdata     (wdata)
    );

endmodule

`default_nettype wire

/* verification/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

    // Release on a rising edge so the core leaves reset cleanly
    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* verification/coreTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "core_defs.svh"

module coreTb
    import isaPkg::*;
();
    localparam int ROM_WORDS = 512;
    localparam int RAM_WORDS = 256;
    localparam int ROUNDS    = 3;
    localparam int TESTS     = 5;

    logic                  clk;
    logic                  reset;
    logic [`XLEN-1:0]      iaddr;
    logic [`XLEN-1:0]      idata;
    logic [`XLEN-1:0]      daddr;
    logic [`XLEN-1:0]      drdata;
    logic [`XLEN-1:0]      dwdata;
    logic [`BYTE_EN_W-1:0] dwe;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] shadowRam [RAM_WORDS];
    logic [31:0] shadowRegs [32];
    logic [31:0] shadowPc = '0;
    logic [31:0] haltAddr = '0;
    int          progLen = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrors = 0;
    int          testIdx = 0;
    int          passedTests = 0;
    int          failedTests = 0;
    int          testEnd [TESTS];
    string       testName [TESTS];
    integer      seed = 32'h1ab3e6c7;
    logic        done = 1'b0;
    logic        resetSeen = 1'b0;

    clockGen #(.PERIOD(40), .RESET_CYCLES(10)) clkGen_i (.clk(clk), .reset(reset));

    riscvCore dut_i (
        .clk    (clk),
        .reset  (reset),
        .iaddr  (iaddr),
        .idata  (idata),
        .daddr  (daddr),
        .drdata (drdata),
        .dwdata (dwdata),
        .dwe    (dwe)
    );

    assign idata  = rom[iaddr[10:2]];    // Combinational ROM
    assign drdata = ram[daddr[9:2]];

    always @(posedge clk)
    begin
        for (int i = 0; i < `BYTE_EN_W; i++)
            if (dwe[i])
                ram[daddr[9:2]][8*i +: 8] <= dwdata[8*i +: 8];
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, ALUR};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic emit(input logic [31:0] instr);
        rom[progLen] = instr;
        progLen++;
    endtask

    // Two instructions always, so jump targets can be computed ahead
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit(encU(upper[19:0], rd, LUI));
        emit(encI(value[11:0], rd, 3'd0, rd, ALUI));
    endtask

    task automatic storeWord(input logic [4:0] rs2, input logic [11:0] offset);
        emit(encS(offset, rs2, 5'd0, F3_SW));
    endtask

    task automatic nop();
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, ALUI));
    endtask

    task automatic buildProgram();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic [2:0]  brF3 [6];
        brF3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        storeWord(5'd0, 12'h3fc);    // A store at the reset address exposes the bus gating
        for (int r = 0; r < ROUNDS; r++)
        begin
            a = $random(seed);
            b = $random(seed);
            if (r == 0)
            begin
                a[31] = 1'b1;    // Signed and unsigned compare disagree
                b[31] = 1'b0;
            end
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int f = 0; f < 8; f++)
            begin
                f3 = 3'(f);
                emit(encR(7'h00, 5'd2, 5'd1, f3, 5'd3));
                storeWord(5'd3, 12'h200);
                if (f3 == F3_ADD || f3 == F3_SR)
                begin
                    emit(encR(7'h20, 5'd2, 5'd1, f3, 5'd3));
                    storeWord(5'd3, 12'h200);
                end
                imm = 12'($random(seed));
                if (f3 == F3_SLL || f3 == F3_SR)
                    imm = (r == 0) ? 12'd31 : {7'd0, imm[4:0]};
                emit(encI(imm, 5'd1, f3, 5'd3, ALUI));
                storeWord(5'd3, 12'h200);
                if (f3 == F3_SR)
                begin
                    emit(encI(imm | 12'h400, 5'd1, f3, 5'd3, ALUI));
                    storeWord(5'd3, 12'h200);
                end
            end
        end
        testEnd[1] = progLen;

        for (int p = 0; p < 3; p++)
        begin
            a = $random(seed);
            b = $random(seed);
            case (p)
                0: b = a;
                1:
                begin
                    a[31] = 1'b1;
                    b[31] = 1'b0;
                end
                default:
                begin
                    a = a | 32'hf000_0000;    // Large unsigned
                    b = b & 32'h0000_00ff;
                end
            endcase
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int k = 0; k < 6; k++)
            begin
                emit(encB(13'd8, 5'd2, 5'd1, brF3[k]));
                nop();    // Skipped when taken
                emit(encB(13'd8, 5'd1, 5'd2, brF3[k]));
                nop();
            end
        end
        testEnd[2] = progLen;

        emit(encJ(21'd8, 5'd5));
        nop();
        storeWord(5'd5, 12'h204);
        target = 32'((progLen + 4) * 4) | 32'd1;    // Odd target, bit 0 must drop
        loadConst(5'd6, target);
        emit(encI(12'd0, 5'd6, 3'd0, 5'd7, JALR));
        nop();
        storeWord(5'd7, 12'h208);
        a = $random(seed);
        emit(encU(a[19:0], 5'd8, LUI));
        storeWord(5'd8, 12'h20c);
        emit(encU(a[31:12], 5'd9, AUIPC));
        storeWord(5'd9, 12'h210);
        testEnd[3] = progLen;

        loadConst(5'd10, $random(seed));
        storeWord(5'd10, 12'h240);
        emit(encI(12'h240, 5'd0, F3_LW, 5'd11, LOAD));
        storeWord(5'd11, 12'h244);
        storeWord(5'd10, 12'h242);                      // Misaligned
        emit(encS(12'h240, 5'd10, 5'd0, 3'd0));         // SB is not supported
        emit(encI(12'h241, 5'd0, F3_LW, 5'd12, LOAD));
        storeWord(5'd12, 12'h248);
        emit(encI(12'h240, 5'd0, 3'd0, 5'd13, LOAD));   // LB reads as zero
        storeWord(5'd13, 12'h24c);
        testEnd[4] = progLen;

        haltAddr = 32'(progLen * 4);
        emit(encJ(21'd0, 5'd0));
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction of the ISA on the shadow state
    function automatic void stepModel(input logic [31:0] instr, output logic [3:0] expDwe,
                                      output logic [31:0] expAddr,
                                      output logic [31:0] expData);
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic        write;
        logic        taken;
        op      = instr[6:0];
        f3      = instr[14:12];
        rd      = instr[11:7];
        a       = shadowRegs[instr[19:15]];
        b       = shadowRegs[instr[24:20]];
        immI    = {{20{instr[31]}}, instr[31:20]};
        immS    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        result  = '0;
        write   = 1'b1;
        taken   = 1'b0;
        nextPc  = shadowPc + 32'd4;
        expDwe  = '0;
        expAddr = a + immS;
        expData = b;
        case (op)
            ALUR:  result = aluRef(f3, instr[30], a, b);
            ALUI:
            begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    result = aluRef(f3, instr[30] && f3 == 3'd5, a, {27'd0, instr[24:20]});
                else
                    result = aluRef(f3, 1'b0, a, immI);
            end
            LUI:   result = {instr[31:12], 12'd0};
            AUIPC: result = shadowPc + {instr[31:12], 12'd0};
            JAL:
            begin
                result = shadowPc + 32'd4;
                nextPc = shadowPc + immJ;
            end
            JALR:
            begin
                result = shadowPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            LOAD:
            begin
                expAddr = a + immI;
                if (f3 == 3'd2 && expAddr[1:0] == 2'b00)
                    result = shadowRam[expAddr[9:2]];
            end
            STORE:
            begin
                write = 1'b0;
                if (f3 == 3'd2 && expAddr[1:0] == 2'b00)
                begin
                    expDwe = 4'hf;
                    shadowRam[expAddr[9:2]] = b;
                end
            end
            BRANCH:
            begin
                write = 1'b0;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nextPc = shadowPc + immB;
            end
            default: write = 1'b0;
        endcase
        if (write && rd != 5'd0)
            shadowRegs[rd] = result;
        shadowPc = nextPc;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            testErrors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0)
            passedTests++;
        else
            failedTests++;
        $display("Test %s: %s (%0d errors)", testName[testIdx],
                 (testErrors == 0) ? "passed" : "failed", testErrors);
        testErrors = 0;
        testIdx++;
    endtask

    // Compare on the falling edge, where all outputs are settled
    always @(negedge clk)
    begin
        logic [3:0]  expDwe;
        logic [31:0] expAddr;
        logic [31:0] expData;
        if (reset)
        begin
            checkValue("iaddr", iaddr, 32'd0);
            checkValue("dwe", {28'd0, dwe}, 32'd0);
            checkValue("daddr", daddr, 32'd0);
            checkValue("dwdata", dwdata, 32'd0);
        end
        else if (!done)
        begin
            if (!resetSeen)
            begin
                resetSeen = 1'b1;
                finishTest();
            end
            checkValue("iaddr", iaddr, shadowPc);
            stepModel(rom[shadowPc[10:2]], expDwe, expAddr, expData);
            checkValue("dwe", {28'd0, dwe}, {28'd0, expDwe});
            if (expDwe != 4'd0 || dwe != 4'd0)
            begin
                checkValue("daddr", daddr, expAddr);
                checkValue("dwdata", dwdata, expData);
            end
            while (testIdx < TESTS && int'(shadowPc[31:2]) >= testEnd[testIdx])
                finishTest();
            if (shadowPc == haltAddr)
                done = 1'b1;
        end
    end

    initial
    begin
        testName = '{"reset", "alu", "branch", "jump", "memory"};
        testEnd[0] = 0;
        for (int i = 0; i < 32; i++)
            shadowRegs[i] = '0;
        for (int i = 0; i < RAM_WORDS; i++)
        begin
            ram[i]       = 32'(i) * 32'h0101_0101 ^ 32'h5a00_00a5;
            shadowRam[i] = 32'(i) * 32'h0101_0101 ^ 32'h5a00_00a5;
        end
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = encI(12'd0, 5'd0, 3'd0, 5'd0, ALUI);
        buildProgram();
        wait (done);
        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 passedTests, failedTests, checkCount, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Twice the program length in clock periods, plus reset
    initial
    begin
        #1;
        #((progLen + 20) * 80);
        $display("Timeout: the program never reached its final instruction");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
